// File: source/apple2_glue_pkg.sv
// Field positions assume the 32-bit menu status word layout of the Apple II+ core menu
package apple2_glue_pkg;

	// ========================================================================
	// Menu status word
	// ========================================================================
	localparam int STATUS_W = 32;

	// Single-bit fields
	localparam int ST_COLD_RESET     = 0;
	localparam int ST_CPU_6502       = 5;
	localparam int ST_JOY_SWAP       = 6;
	localparam int ST_TEXT_COMPOSITE = 21;

	// Low bit of each 2-bit field
	localparam int ST_PDL_LO     = 17;
	localparam int ST_SCREEN_LO  = 19;
	localparam int ST_PALETTE_LO = 24;
	localparam int ST_SLOT4_LO   = 28;
	localparam int ST_SLOT5_LO   = 30;

	localparam int MODE_W = 2;

	// Display mode 0 is the colour monitor
	localparam logic [MODE_W-1:0] SCREEN_COLOR = 2'd0;

	// Slot card codes, in menu order
	localparam logic [MODE_W-1:0] SLOT4_SOUND   = 2'd0;
	localparam logic [MODE_W-1:0] SLOT4_MOUSE   = 2'd1;
	localparam logic [MODE_W-1:0] SLOT5_RAMCARD = 2'd0;
	localparam logic [MODE_W-1:0] SLOT5_SOUND   = 2'd1;
	localparam logic [MODE_W-1:0] SLOT5_MOUSE   = 2'd2;

	// Paddle-as-analog selection
	localparam logic [MODE_W-1:0] PDL_X = 2'd1;
	localparam logic [MODE_W-1:0] PDL_Y = 2'd2;

	// ========================================================================
	// Memory, joystick and media
	// ========================================================================
	localparam int BYTE_W      = 8;
	localparam int MAIN_ADDR_W = 18;
	localparam int MAIN_DEPTH  = 196608;
	localparam int AUX_ADDR_W  = 16;
	localparam int AUX_DEPTH   = 65536;

	localparam int JOY_W     = 16;
	localparam int JOY_DIG_W = 6;

	localparam int IMG_SIZE_W = 64;

	// Bit index of each medium in img_mounted
	localparam int MEDIA_FD1 = 0;
	localparam int MEDIA_HDD = 1;
	localparam int MEDIA_FD2 = 2;

endpackage

// File: source/option_ctrl.sv
// Keyboard toggle pulses are one cycle wide and must be at least two cycles apart
module option_ctrl (
	input  logic                                  clk_sys,
	input  logic                                  dd_reset,
	input  logic [apple2_glue_pkg::STATUS_W-1:0] status,
	input  logic                                  video_toggle,
	input  logic                                  palette_toggle,
	output logic [apple2_glue_pkg::STATUS_W-1:0] status_in,
	output logic                                  status_set,
	output logic                                  text_color,
	output logic                                  cpu_65c02,
	output logic                                  slot4_sound,
	output logic                                  slot4_mouse,
	output logic                                  slot5_ramcard,
	output logic                                  slot5_sound,
	output logic                                  slot5_mouse
);

	logic [apple2_glue_pkg::MODE_W-1:0] screen_mode;
	logic [apple2_glue_pkg::MODE_W-1:0] palette_mode;
	logic [apple2_glue_pkg::MODE_W-1:0] slot4_code;
	logic [apple2_glue_pkg::MODE_W-1:0] slot5_code;
	logic [apple2_glue_pkg::MODE_W-1:0] screen_req;
	logic [apple2_glue_pkg::MODE_W-1:0] palette_req;

	assign screen_mode  = status[apple2_glue_pkg::ST_SCREEN_LO +: apple2_glue_pkg::MODE_W];
	assign palette_mode = status[apple2_glue_pkg::ST_PALETTE_LO +: apple2_glue_pkg::MODE_W];
	assign slot4_code   = status[apple2_glue_pkg::ST_SLOT4_LO +: apple2_glue_pkg::MODE_W];
	assign slot5_code   = status[apple2_glue_pkg::ST_SLOT5_LO +: apple2_glue_pkg::MODE_W];

	// Card selection straight from the menu
	assign slot4_sound   = slot4_code == apple2_glue_pkg::SLOT4_SOUND;
	assign slot4_mouse   = slot4_code == apple2_glue_pkg::SLOT4_MOUSE;
	assign slot5_ramcard = slot5_code == apple2_glue_pkg::SLOT5_RAMCARD;
	assign slot5_sound   = slot5_code == apple2_glue_pkg::SLOT5_SOUND;
	assign slot5_mouse   = slot5_code == apple2_glue_pkg::SLOT5_MOUSE;

	// Composite text artifacts only make sense on the colour monitor
	always_ff @(posedge clk_sys) begin
		text_color <= (screen_mode == apple2_glue_pkg::SCREEN_COLOR) &&
			status[apple2_glue_pkg::ST_TEXT_COMPOSITE];
		cpu_65c02  <= ~status[apple2_glue_pkg::ST_CPU_6502];
	end

	// ========================================================================
	// Keyboard change requests
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			status_set <= 1'b0;
		end else begin
			status_set <= video_toggle | palette_toggle;
		end
	end

	// Palette change forces the colour screen and overrides a video toggle
	always_ff @(posedge clk_sys) begin
		if (palette_toggle) begin
			palette_req <= palette_mode + 1'b1;
			screen_req  <= apple2_glue_pkg::SCREEN_COLOR;
		end else if (video_toggle) begin
			palette_req <= palette_mode;
			screen_req  <= screen_mode + 1'b1;
		end
	end

	always_comb begin
		status_in = status;
		if (status_set) begin
			status_in[apple2_glue_pkg::ST_SCREEN_LO +: apple2_glue_pkg::MODE_W]  = screen_req;
			status_in[apple2_glue_pkg::ST_PALETTE_LO +: apple2_glue_pkg::MODE_W] = palette_req;
		end
	end

	// The host sees one write per keyboard request
	a_single_set: assert property (@(posedge clk_sys) disable iff (dd_reset)
		status_set |=> !status_set);

endmodule

// File: source/joystick_map.sv
// Paddle codes other than X and Y leave both analog bytes on the stick
module joystick_map (
	input  logic                                   clk_sys,
	input  logic                                   swap_axes,
	input  logic [apple2_glue_pkg::MODE_W-1:0]    paddle_sel,
	input  logic [apple2_glue_pkg::JOY_DIG_W-1:0] joystick_dig,
	input  logic [apple2_glue_pkg::JOY_W-1:0]     joystick_ana,
	input  logic [apple2_glue_pkg::BYTE_W-1:0]    paddle,
	output logic [apple2_glue_pkg::JOY_DIG_W-1:0] joy_dig,
	output logic [apple2_glue_pkg::JOY_W-1:0]     joy_an
);

	localparam int BW = apple2_glue_pkg::BYTE_W;

	logic [BW-1:0]                         pdl;
	logic [apple2_glue_pkg::JOY_W-1:0]     joys;
	logic [apple2_glue_pkg::JOY_W-1:0]     joya;
	logic [apple2_glue_pkg::JOY_DIG_W-1:0] dig_mask;

	// Paddle reads are centred around 0x80 on the Apple side
	assign pdl = {~paddle[BW-1], paddle[BW-2:0]};

	// Host word has the axes in the opposite byte order unless swapped in the menu
	assign joys = swap_axes ? joystick_ana : {joystick_ana[BW-1:0], joystick_ana[2*BW-1:BW]};

	assign joya[2*BW-1:BW] = (paddle_sel == apple2_glue_pkg::PDL_X) ? pdl : joys[2*BW-1:BW];
	assign joya[BW-1:0]    = (paddle_sel == apple2_glue_pkg::PDL_Y) ? pdl : joys[BW-1:0];

	// Digital directions are ignored on an axis that is deflected
	assign dig_mask = {2'b11, {2{~|joys[BW-1:0]}}, {2{~|joys[2*BW-1:BW]}}};

	always_ff @(posedge clk_sys) begin
		joy_an  <= joya;
		joy_dig <= joystick_dig & dig_mask;
	end

endmodule

// File: source/system_ram.sv
// Main bank addresses at or above 196608 are outside the array and must not be used
module system_ram (
	input  logic                                     clk_sys,
	input  logic [apple2_glue_pkg::MAIN_ADDR_W-1:0] ram_addr,
	input  logic [apple2_glue_pkg::BYTE_W-1:0]      ram_din,
	input  logic                                     ram_we,
	input  logic                                     ram_aux,
	output logic [2*apple2_glue_pkg::BYTE_W-1:0]    ram_dout
);

	logic [apple2_glue_pkg::BYTE_W-1:0] main_mem [apple2_glue_pkg::MAIN_DEPTH];
	logic [apple2_glue_pkg::BYTE_W-1:0] aux_mem  [apple2_glue_pkg::AUX_DEPTH];

	logic [apple2_glue_pkg::AUX_ADDR_W-1:0] aux_addr;
	logic                                   main_we;
	logic                                   aux_we;

	assign aux_addr = ram_addr[apple2_glue_pkg::AUX_ADDR_W-1:0];
	assign main_we  = ram_we & ~ram_aux;
	assign aux_we   = ram_we & ram_aux;

	// ========================================================================
	// Main bank, low byte of ram_dout
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (main_we) begin
			main_mem[ram_addr] <= ram_din;
			ram_dout[apple2_glue_pkg::BYTE_W-1:0] <= ram_din;
		end else begin
			ram_dout[apple2_glue_pkg::BYTE_W-1:0] <= main_mem[ram_addr];
		end
	end

	// ========================================================================
	// Auxiliary bank, high byte of ram_dout
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (aux_we) begin
			aux_mem[aux_addr] <= ram_din;
			ram_dout[2*apple2_glue_pkg::BYTE_W-1:apple2_glue_pkg::BYTE_W] <= ram_din;
		end else begin
			ram_dout[2*apple2_glue_pkg::BYTE_W-1:apple2_glue_pkg::BYTE_W] <= aux_mem[aux_addr];
		end
	end

	// Main bank is 192 KiB, so the top quarter of the address space is a hole
	a_main_range: assert property (@(posedge clk_sys)
		main_we |-> (ram_addr < apple2_glue_pkg::MAIN_DEPTH));

endmodule

// File: source/hdd_request_seq.sv
// Requests arriving before the host ack rises merge into the running transfer
module hdd_request_seq (
	input  logic clk_sys,
	input  logic dd_reset,
	input  logic hdd_read,
	input  logic hdd_write,
	input  logic hdd_ack,
	output logic hdd_rd,
	output logic hdd_wr,
	output logic cpu_wait
);

	logic rd_pending;
	logic wr_pending;
	logic ack_q;
	logic ack_rise;
	logic ack_fall;
	logic rd_want;
	logic wr_want;

	assign ack_rise = hdd_ack & ~ack_q;
	assign ack_fall = ~hdd_ack & ack_q;

	// A fresh pulse counts as pending in the same cycle
	assign rd_want = rd_pending | hdd_read;
	assign wr_want = wr_pending | hdd_write;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hdd_ack;
		end
	end

	// ========================================================================
	// Sequencer, cpu_wait is the busy state
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
			hdd_rd     <= 1'b0;
			hdd_wr     <= 1'b0;
			cpu_wait   <= 1'b0;
		end else if (!cpu_wait) begin
			rd_pending <= rd_want;
			wr_pending <= wr_want;
			if (rd_want | wr_want) begin
				hdd_rd   <= rd_want;
				hdd_wr   <= wr_want;
				cpu_wait <= 1'b1;
			end
		end else if (ack_rise) begin
			// Host took the request, anything new from here on is the next one
			rd_pending <= hdd_read;
			wr_pending <= hdd_write;
			hdd_rd     <= 1'b0;
			hdd_wr     <= 1'b0;
		end else begin
			rd_pending <= rd_want;
			wr_pending <= wr_want;
			if (ack_fall) begin
				cpu_wait <= 1'b0;
			end
		end
	end

	// The CPU is always held while a request is presented to the host
	a_req_holds_cpu: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(hdd_rd || hdd_wr) |-> cpu_wait);

	a_reset_releases: assert property (@(posedge clk_sys)
		dd_reset |=> !cpu_wait);

endmodule

// File: source/media_mount_tracker.sv
// img_size and img_readonly are only sampled in the cycle of an img_mounted pulse
module media_mount_tracker (
	input  logic                                    clk_sys,
	input  logic                                    dd_reset,
	input  logic [apple2_glue_pkg::MEDIA_FD2:0]    img_mounted,
	input  logic [apple2_glue_pkg::IMG_SIZE_W-1:0] img_size,
	input  logic                                    img_readonly,
	output logic [1:0]                              disk_mount,
	output logic [1:0]                              disk_change,
	output logic                                    hdd_mounted,
	output logic                                    hdd_protect
);

	logic has_image;

	// Zero size means the image was ejected
	assign has_image = |img_size;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			disk_mount  <= 2'b00;
			disk_change <= 2'b00;
			hdd_mounted <= 1'b0;
		end else begin
			if (img_mounted[apple2_glue_pkg::MEDIA_FD1]) begin
				disk_mount[0]  <= has_image;
				disk_change[0] <= ~disk_change[0];
			end
			if (img_mounted[apple2_glue_pkg::MEDIA_FD2]) begin
				disk_mount[1]  <= has_image;
				disk_change[1] <= ~disk_change[1];
			end
			if (img_mounted[apple2_glue_pkg::MEDIA_HDD]) begin
				hdd_mounted <= has_image;
			end
		end
	end

	// Write protect of the hard disk image
	always_ff @(posedge clk_sys) begin
		if (img_mounted[apple2_glue_pkg::MEDIA_HDD]) begin
			hdd_protect <= img_readonly;
		end
	end

endmodule

// File: source/apple2_glue_top.sv
// Everything runs on clk_sys and inputs are expected synchronous to it
module apple2_glue_top (
	input  logic                                     clk_sys,
	input  logic                                     dd_reset,
	// Menu and keyboard
	input  logic [apple2_glue_pkg::STATUS_W-1:0]    status,
	input  logic                                     video_toggle,
	input  logic                                     palette_toggle,
	output logic [apple2_glue_pkg::STATUS_W-1:0]    status_in,
	output logic                                     status_set,
	output logic                                     text_color,
	output logic                                     cpu_65c02,
	output logic                                     slot4_sound,
	output logic                                     slot4_mouse,
	output logic                                     slot5_ramcard,
	output logic                                     slot5_sound,
	output logic                                     slot5_mouse,
	// Joystick
	input  logic [apple2_glue_pkg::JOY_DIG_W-1:0]   joystick_dig,
	input  logic [apple2_glue_pkg::JOY_W-1:0]       joystick_ana,
	input  logic [apple2_glue_pkg::BYTE_W-1:0]      paddle,
	output logic [apple2_glue_pkg::JOY_DIG_W-1:0]   joy_dig,
	output logic [apple2_glue_pkg::JOY_W-1:0]       joy_an,
	// System RAM
	input  logic [apple2_glue_pkg::MAIN_ADDR_W-1:0] ram_addr,
	input  logic [apple2_glue_pkg::BYTE_W-1:0]      ram_din,
	input  logic                                     ram_we,
	input  logic                                     ram_aux,
	output logic [2*apple2_glue_pkg::BYTE_W-1:0]    ram_dout,
	// Hard disk host requests
	input  logic                                     hdd_read,
	input  logic                                     hdd_write,
	input  logic                                     hdd_ack,
	output logic                                     hdd_rd,
	output logic                                     hdd_wr,
	output logic                                     cpu_wait,
	// Media
	input  logic [apple2_glue_pkg::MEDIA_FD2:0]     img_mounted,
	input  logic [apple2_glue_pkg::IMG_SIZE_W-1:0]  img_size,
	input  logic                                     img_readonly,
	output logic [1:0]                               disk_mount,
	output logic [1:0]                               disk_change,
	output logic                                     hdd_mounted,
	output logic                                     hdd_protect
);

	option_ctrl u_option_ctrl (
		.clk_sys        (clk_sys),
		.dd_reset       (dd_reset),
		.status         (status),
		.video_toggle   (video_toggle),
		.palette_toggle (palette_toggle),
		.status_in      (status_in),
		.status_set     (status_set),
		.text_color     (text_color),
		.cpu_65c02      (cpu_65c02),
		.slot4_sound    (slot4_sound),
		.slot4_mouse    (slot4_mouse),
		.slot5_ramcard  (slot5_ramcard),
		.slot5_sound    (slot5_sound),
		.slot5_mouse    (slot5_mouse)
	);

	joystick_map u_joystick_map (
		.clk_sys      (clk_sys),
		.swap_axes    (status[apple2_glue_pkg::ST_JOY_SWAP]),
		.paddle_sel   (status[apple2_glue_pkg::ST_PDL_LO +: apple2_glue_pkg::MODE_W]),
		.joystick_dig (joystick_dig),
		.joystick_ana (joystick_ana),
		.paddle       (paddle),
		.joy_dig      (joy_dig),
		.joy_an       (joy_an)
	);

	system_ram u_system_ram (
		.clk_sys  (clk_sys),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_we   (ram_we),
		.ram_aux  (ram_aux),
		.ram_dout (ram_dout)
	);

	hdd_request_seq u_hdd_request_seq (
		.clk_sys   (clk_sys),
		.dd_reset  (dd_reset),
		.hdd_read  (hdd_read),
		.hdd_write (hdd_write),
		.hdd_ack   (hdd_ack),
		.hdd_rd    (hdd_rd),
		.hdd_wr    (hdd_wr),
		.cpu_wait  (cpu_wait)
	);

	media_mount_tracker u_media_mount_tracker (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.disk_mount   (disk_mount),
		.disk_change  (disk_change),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

endmodule

// File: tb/tb_checks.svh
// Included inside the testbench module after clk_sys is declared; first mismatch ends the run
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// The tests take a few hundred cycles, the watchdog allows far more
localparam int TEST_CYCLES_EST = 10000;
localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES_EST;

int          error_count = 0;
logic [31:0] rng_state   = 32'hd6ee_4a2a;

task automatic check_equal(input string name, input logic [63:0] got,
	input logic [63:0] expected);
	if (got !== expected) begin
		error_count++;
		$display("MISMATCH at time %0t: %s = 0x%0h, expected 0x%0h",
			$time, name, got, expected);
		$display("Checks failed");
		$fatal(1);
	end
endtask

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] v;
	v = x;
	v = v ^ (v << 13);
	v = v ^ (v >> 17);
	v = v ^ (v << 5);
	return v;
endfunction

function automatic logic [31:0] next_random();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// Watchdog
initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
	$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
	$display("Checks failed");
	$fatal(1);
end

`endif

// File: tb/tb_apple2_glue.sv
// Inputs change on the falling edge of clk_sys and outputs are checked on the next falling edge
module tb_apple2_glue;

	logic        clk_sys;
	logic        dd_reset;
	logic [31:0] status;
	logic        video_toggle;
	logic        palette_toggle;
	logic [31:0] status_in;
	logic        status_set;
	logic        text_color;
	logic        cpu_65c02;
	logic        slot4_sound;
	logic        slot4_mouse;
	logic        slot5_ramcard;
	logic        slot5_sound;
	logic        slot5_mouse;
	logic [5:0]  joystick_dig;
	logic [15:0] joystick_ana;
	logic [7:0]  paddle;
	logic [5:0]  joy_dig;
	logic [15:0] joy_an;
	logic [17:0] ram_addr;
	logic [7:0]  ram_din;
	logic        ram_we;
	logic        ram_aux;
	logic [15:0] ram_dout;
	logic        hdd_read;
	logic        hdd_write;
	logic        hdd_ack;
	logic        hdd_rd;
	logic        hdd_wr;
	logic        cpu_wait;
	logic [2:0]  img_mounted;
	logic [63:0] img_size;
	logic        img_readonly;
	logic [1:0]  disk_mount;
	logic [1:0]  disk_change;
	logic        hdd_mounted;
	logic        hdd_protect;

	// Reference state for RAM and media
	logic [7:0] main_model [int];
	logic [7:0] aux_model [int];
	int         main_addrs [$];
	int         aux_addrs [$];
	logic [1:0] exp_disk_mount;
	logic [1:0] exp_disk_change;
	logic       exp_hdd_mounted;
	logic       exp_hdd_protect;

	`include "tb_checks.svh"

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	apple2_glue_top uut (
		.clk_sys        (clk_sys),
		.dd_reset       (dd_reset),
		.status         (status),
		.video_toggle   (video_toggle),
		.palette_toggle (palette_toggle),
		.status_in      (status_in),
		.status_set     (status_set),
		.text_color     (text_color),
		.cpu_65c02      (cpu_65c02),
		.slot4_sound    (slot4_sound),
		.slot4_mouse    (slot4_mouse),
		.slot5_ramcard  (slot5_ramcard),
		.slot5_sound    (slot5_sound),
		.slot5_mouse    (slot5_mouse),
		.joystick_dig   (joystick_dig),
		.joystick_ana   (joystick_ana),
		.paddle         (paddle),
		.joy_dig        (joy_dig),
		.joy_an         (joy_an),
		.ram_addr       (ram_addr),
		.ram_din        (ram_din),
		.ram_we         (ram_we),
		.ram_aux        (ram_aux),
		.ram_dout       (ram_dout),
		.hdd_read       (hdd_read),
		.hdd_write      (hdd_write),
		.hdd_ack        (hdd_ack),
		.hdd_rd         (hdd_rd),
		.hdd_wr         (hdd_wr),
		.cpu_wait       (cpu_wait),
		.img_mounted    (img_mounted),
		.img_size       (img_size),
		.img_readonly   (img_readonly),
		.disk_mount     (disk_mount),
		.disk_change    (disk_change),
		.hdd_mounted    (hdd_mounted),
		.hdd_protect    (hdd_protect)
	);

	task automatic next_cycle();
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	function automatic logic [31:0] put_field(input logic [31:0] word, input int lo,
		input logic [1:0] value);
		word[lo +: 2] = value;
		return word;
	endfunction

	// ========================================================================
	// RAM: write-through, then readback against the model
	// ========================================================================
	task automatic ram_write_readback();
		int         a;
		logic [7:0] d;
		ram_we = 1'b1;
		ram_aux = 1'b0;
		for (int i = 0; i < 32; i++) begin
			a = int'(next_random() % apple2_glue_pkg::MAIN_DEPTH);
			d = 8'(next_random());
			ram_addr = 18'(a);
			ram_din = d;
			next_cycle();
			check_equal("ram_dout[7:0] main write", ram_dout[7:0], d);
			main_model[a] = d;
			main_addrs.push_back(a);
		end
		// Aux bank only sees the low 16 address bits
		// Aux writes reuse the main addresses so the main byte beside them is known
		ram_aux = 1'b1;
		for (int i = 0; i < 32; i++) begin
			a = main_addrs[i];
			d = 8'(next_random());
			ram_addr = 18'(a);
			ram_din = d;
			next_cycle();
			check_equal("ram_dout[15:8] aux write", ram_dout[15:8], d);
			check_equal("ram_dout[7:0] during aux write", ram_dout[7:0], main_model[a]);
			aux_model[a & 16'hffff] = d;
			aux_addrs.push_back(a & 16'hffff);
		end
		ram_we = 1'b0;
		ram_aux = 1'b0;
		foreach (main_addrs[i]) begin
			ram_addr = 18'(main_addrs[i]);
			next_cycle();
			check_equal("ram_dout[7:0] main read", ram_dout[7:0], main_model[main_addrs[i]]);
		end
		ram_aux = 1'b1;
		foreach (aux_addrs[i]) begin
			ram_addr = 18'(aux_addrs[i]);
			next_cycle();
			check_equal("ram_dout[15:8] aux read", ram_dout[15:8], aux_model[aux_addrs[i]]);
		end
		ram_aux = 1'b0;
	endtask

	// ========================================================================
	// Hard disk request/acknowledge
	// ========================================================================
	task automatic hdd_transfer_sequence();
		hdd_read = 1'b1;
		next_cycle();
		hdd_read = 1'b0;
		check_equal("hdd_rd", hdd_rd, 1'b1);
		check_equal("hdd_wr", hdd_wr, 1'b0);
		check_equal("cpu_wait", cpu_wait, 1'b1);
		// Host takes its time before accepting
		repeat (3) next_cycle();
		check_equal("hdd_rd before ack", hdd_rd, 1'b1);
		hdd_ack = 1'b1;
		next_cycle();
		check_equal("hdd_rd after ack rise", hdd_rd, 1'b0);
		check_equal("cpu_wait after ack rise", cpu_wait, 1'b1);
		// Write arrives mid-transfer and has to wait
		hdd_write = 1'b1;
		next_cycle();
		hdd_write = 1'b0;
		check_equal("hdd_wr while busy", hdd_wr, 1'b0);
		next_cycle();
		hdd_ack = 1'b0;
		next_cycle();
		check_equal("cpu_wait after ack fall", cpu_wait, 1'b0);
		next_cycle();
		check_equal("hdd_wr pending start", hdd_wr, 1'b1);
		check_equal("hdd_rd pending start", hdd_rd, 1'b0);
		check_equal("cpu_wait pending start", cpu_wait, 1'b1);
		hdd_ack = 1'b1;
		next_cycle();
		check_equal("hdd_wr after ack rise", hdd_wr, 1'b0);
		hdd_ack = 1'b0;
		next_cycle();
		check_equal("cpu_wait second release", cpu_wait, 1'b0);
		next_cycle();
		check_equal("cpu_wait stays idle", cpu_wait, 1'b0);
		check_equal("hdd_rd stays idle", hdd_rd, 1'b0);
		check_equal("hdd_wr stays idle", hdd_wr, 1'b0);
	endtask

	// ========================================================================
	// Media mounting
	// ========================================================================
	task automatic mount_pulse(input int idx, input logic [63:0] size, input logic ro);
		img_mounted = 3'(1 << idx);
		img_size = size;
		img_readonly = ro;
		next_cycle();
		img_mounted = 3'b000;
		img_size = 64'h0;
		img_readonly = 1'b0;
		if (idx == apple2_glue_pkg::MEDIA_FD1) begin
			exp_disk_mount[0] = size != 64'h0;
			exp_disk_change[0] = ~exp_disk_change[0];
		end else if (idx == apple2_glue_pkg::MEDIA_FD2) begin
			exp_disk_mount[1] = size != 64'h0;
			exp_disk_change[1] = ~exp_disk_change[1];
		end else begin
			exp_hdd_mounted = size != 64'h0;
			exp_hdd_protect = ro;
		end
		check_equal("disk_mount", disk_mount, exp_disk_mount);
		check_equal("disk_change", disk_change, exp_disk_change);
		check_equal("hdd_mounted", hdd_mounted, exp_hdd_mounted);
		// hdd_protect is unknown until the first hard disk mount
		if (exp_hdd_protect !== 1'bx)
			check_equal("hdd_protect", hdd_protect, exp_hdd_protect);
	endtask

	task automatic media_mount_updates();
		mount_pulse(apple2_glue_pkg::MEDIA_FD1, 64'd143360, 1'b0);
		mount_pulse(apple2_glue_pkg::MEDIA_FD1, 64'd0, 1'b0);
		mount_pulse(apple2_glue_pkg::MEDIA_FD2, 64'd143360, 1'b1);
		mount_pulse(apple2_glue_pkg::MEDIA_HDD, 64'h200_0000, 1'b1);
		mount_pulse(apple2_glue_pkg::MEDIA_HDD, 64'd0, 1'b0);
		// A read-only floppy must leave the hard disk protect flag alone
		mount_pulse(apple2_glue_pkg::MEDIA_FD2, 64'd0, 1'b1);
		// Only the upper word of the size is nonzero
		mount_pulse(apple2_glue_pkg::MEDIA_HDD, 64'h1_0000_0000, 1'b0);
	endtask

	// ========================================================================
	// Display and palette requests
	// ========================================================================
	task automatic toggle_case(input logic [1:0] scr, input logic [1:0] pal,
		input logic video, input logic pal_tgl);
		logic [31:0] base;
		logic [31:0] expected;
		base = put_field(32'h4213_8c21, apple2_glue_pkg::ST_SCREEN_LO, scr);
		base = put_field(base, apple2_glue_pkg::ST_PALETTE_LO, pal);
		status = base;
		next_cycle();
		check_equal("status_set idle", status_set, 1'b0);
		check_equal("status_in idle", status_in, base);
		if (pal_tgl) begin
			expected = put_field(base, apple2_glue_pkg::ST_PALETTE_LO, 2'(pal + 2'd1));
			expected = put_field(expected, apple2_glue_pkg::ST_SCREEN_LO, 2'd0);
		end else begin
			expected = put_field(base, apple2_glue_pkg::ST_SCREEN_LO, 2'(scr + 2'd1));
		end
		video_toggle = video;
		palette_toggle = pal_tgl;
		next_cycle();
		video_toggle = 1'b0;
		palette_toggle = 1'b0;
		check_equal("status_set pulse", status_set, 1'b1);
		check_equal("status_in request", status_in, expected);
		next_cycle();
		check_equal("status_set after pulse", status_set, 1'b0);
		check_equal("status_in after pulse", status_in, base);
	endtask

	task automatic display_requests();
		toggle_case(2'd2, 2'd1, 1'b1, 1'b0);
		toggle_case(2'd3, 2'd0, 1'b1, 1'b0);
		toggle_case(2'd2, 2'd3, 1'b0, 1'b1);
		toggle_case(2'd1, 2'd2, 1'b1, 1'b1);
		// Composite text needs the colour screen
		for (int scr = 0; scr < 4; scr++) begin
			for (int comp = 0; comp < 2; comp++) begin
				status = put_field(32'h0, apple2_glue_pkg::ST_SCREEN_LO, 2'(scr));
				status[apple2_glue_pkg::ST_TEXT_COMPOSITE] = comp[0];
				next_cycle();
				check_equal("text_color", text_color, (scr == 0) && comp[0]);
			end
		end
	endtask

	// ========================================================================
	// Joystick mapping, slot codes and CPU type
	// ========================================================================
	task automatic joystick_and_slots();
		logic [31:0] r;
		logic [15:0] joys;
		logic [15:0] exp_an;
		logic [5:0]  exp_dig;
		logic [7:0]  pdl_v;
		for (int i = 0; i < 6; i++) begin
			r = next_random();
			joystick_ana = r[15:0];
			joystick_dig = r[21:16];
			paddle = r[31:24];
			if (i % 3 == 1)
				joystick_ana[7:0] = 8'h00;
			else if (i % 3 == 2)
				joystick_ana[15:8] = 8'h00;
			for (int sw = 0; sw < 2; sw++) begin
				for (int pd = 0; pd < 4; pd++) begin
					status = put_field(32'h0, apple2_glue_pkg::ST_PDL_LO, 2'(pd));
					status[apple2_glue_pkg::ST_JOY_SWAP] = sw[0];
					next_cycle();
					joys = sw[0] ? joystick_ana : {joystick_ana[7:0], joystick_ana[15:8]};
					pdl_v = paddle ^ 8'h80;
					exp_an[15:8] = (pd == 1) ? pdl_v : joys[15:8];
					exp_an[7:0] = (pd == 2) ? pdl_v : joys[7:0];
					exp_dig[5:4] = joystick_dig[5:4];
					exp_dig[3:2] = (joys[7:0] == 8'h00) ? joystick_dig[3:2] : 2'b00;
					exp_dig[1:0] = (joys[15:8] == 8'h00) ? joystick_dig[1:0] : 2'b00;
					check_equal("joy_an", joy_an, exp_an);
					check_equal("joy_dig", joy_dig, exp_dig);
				end
			end
		end
		for (int s4 = 0; s4 < 4; s4++) begin
			for (int s5 = 0; s5 < 4; s5++) begin
				for (int cpu = 0; cpu < 2; cpu++) begin
					status = put_field(32'h0, apple2_glue_pkg::ST_SLOT4_LO, 2'(s4));
					status = put_field(status, apple2_glue_pkg::ST_SLOT5_LO, 2'(s5));
					status[apple2_glue_pkg::ST_CPU_6502] = cpu[0];
					next_cycle();
					check_equal("slot4_sound", slot4_sound, s4 == 0);
					check_equal("slot4_mouse", slot4_mouse, s4 == 1);
					check_equal("slot5_ramcard", slot5_ramcard, s5 == 0);
					check_equal("slot5_sound", slot5_sound, s5 == 1);
					check_equal("slot5_mouse", slot5_mouse, s5 == 2);
					check_equal("cpu_65c02", cpu_65c02, !cpu[0]);
				end
			end
		end
	endtask

	initial begin
		dd_reset = 1'b1;
		status = 32'h0;
		video_toggle = 1'b0;
		palette_toggle = 1'b0;
		joystick_dig = 6'h0;
		joystick_ana = 16'h0;
		paddle = 8'h0;
		ram_addr = 18'h0;
		ram_din = 8'h0;
		ram_we = 1'b0;
		ram_aux = 1'b0;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		hdd_ack = 1'b0;
		img_mounted = 3'b000;
		img_size = 64'h0;
		img_readonly = 1'b0;
		exp_disk_mount = 2'b00;
		exp_disk_change = 2'b00;
		exp_hdd_mounted = 1'b0;
		exp_hdd_protect = 1'bx;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_equal("status_set in reset", status_set, 1'b0);
		check_equal("hdd_rd in reset", hdd_rd, 1'b0);
		check_equal("hdd_wr in reset", hdd_wr, 1'b0);
		check_equal("cpu_wait in reset", cpu_wait, 1'b0);
		check_equal("disk_mount in reset", disk_mount, 2'b00);
		check_equal("disk_change in reset", disk_change, 2'b00);
		check_equal("hdd_mounted in reset", hdd_mounted, 1'b0);
		dd_reset = 1'b0;
		next_cycle();
		ram_write_readback();
		hdd_transfer_sequence();
		media_mount_updates();
		display_requests();
		joystick_and_slots();
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+tb
source/apple2_glue_pkg.sv
source/option_ctrl.sv
source/joystick_map.sv
source/system_ram.sv
source/hdd_request_seq.sv
source/media_mount_tracker.sv
source/apple2_glue_top.sv
tb/tb_apple2_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_apple2_glue -f build.f -o tb_apple2_glue &&
./obj_dir/tb_apple2_glue | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
